/* Bender.yml */
package:
  name: tile_bus

sources:
  - common/tile_pkg.sv
  - common/ahb_if.sv
  - hw/bus/tile_bus_arbiter.sv
  - hw/bus/tile_bus_decoder.sv
  - hw/mem/tile_sram.sv
  - hw/mem/tile_bootrom.sv
  - hw/tile_top.sv
  - target: test
    files:
      - verif/tile_tb.sv

/* common/ahb_if.sv */
`timescale 1ns/1ps

interface ahb_if import tile_pkg::*; ();

  // Request, master to slave
  logic                  hsel;
  logic [ADDR_WIDTH-1:0] haddr;
  logic [DATA_WIDTH-1:0] hwdata;
  logic                  hwrite;
  hsize_e                hsize;
  htrans_e               htrans;

  // Response, slave to master
  logic [DATA_WIDTH-1:0] hrdata;
  logic                  hready;
  logic                  hresp;

  modport master (
    output hsel, haddr, hwdata, hwrite, hsize, htrans,
    input  hrdata, hready, hresp
  );

  modport slave (
    input  hsel, haddr, hwdata, hwrite, hsize, htrans,
    output hrdata, hready, hresp
  );

endinterface

/* common/tile_pkg.sv */
package tile_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Address map, top four address bits select the region
  localparam int         REGION_MSB  = 31;
  localparam int         REGION_LSB  = 28;
  localparam logic [3:0] REGION_SRAM = 4'h0;
  localparam logic [3:0] REGION_EXT  = 4'he;
  localparam logic [3:0] REGION_BOOT = 4'hf;

  // Local SRAM
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_AW    = 10;

  // Boot ROM contents
  localparam int BOOT_WORDS = 8;
  localparam logic [DATA_WIDTH-1:0] BOOT_TABLE [0:BOOT_WORDS-1] = '{
    32'h0000_0297,
    32'h0202_8293,
    32'h0002_a303,
    32'h0042_a383,
    32'h0063_a023,
    32'h0000_0013,
    32'h0003_0067,
    32'hdead_beef
  };

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  typedef enum logic [1:0] {
    SLV_SRAM,
    SLV_BOOT,
    SLV_EXT,
    SLV_NONE
  } slave_e;

  typedef enum logic {
    MST_CORE,
    MST_NET
  } master_e;

endpackage

/* hw/bus/tile_bus_arbiter.sv */
`timescale 1ns/1ps

module tile_bus_arbiter import tile_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  m0_hsel_i,
  input  logic [ADDR_WIDTH-1:0] m0_haddr_i,
  input  logic [DATA_WIDTH-1:0] m0_hwdata_i,
  input  logic                  m0_hwrite_i,
  input  logic [2:0]            m0_hsize_i,
  input  logic [1:0]            m0_htrans_i,
  output logic [DATA_WIDTH-1:0] m0_hrdata_o,
  output logic                  m0_hready_o,
  output logic                  m0_hresp_o,

  input  logic                  m1_hsel_i,
  input  logic [ADDR_WIDTH-1:0] m1_haddr_i,
  input  logic [DATA_WIDTH-1:0] m1_hwdata_i,
  input  logic                  m1_hwrite_i,
  input  logic [2:0]            m1_hsize_i,
  input  logic [1:0]            m1_htrans_i,
  output logic [DATA_WIDTH-1:0] m1_hrdata_o,
  output logic                  m1_hready_o,
  output logic                  m1_hresp_o,

  ahb_if.master                 bus
);

  logic [1:0]            req;
  logic [1:0]            own;
  logic [1:0]            lose;
  logic [1:0]            hready;
  logic [1:0]            pend;
  logic [1:0]            hold_resp;
  logic [DATA_WIDTH-1:0] hold_rdata [0:1];
  master_e               grant;
  master_e               owner;
  logic                  dp_valid;

  assign req[MST_CORE] = m0_hsel_i && (m0_htrans_i == HTRANS_NONSEQ);
  assign req[MST_NET]  = m1_hsel_i && (m1_htrans_i == HTRANS_NONSEQ);

  // Round robin, owner is also the last granted master
  always_comb begin
    if (req[MST_CORE] && req[MST_NET]) begin
      grant = (owner == MST_CORE) ? MST_NET : MST_CORE;
    end else if (req[MST_NET]) begin
      grant = MST_NET;
    end else begin
      grant = MST_CORE;
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      own[i]    = dp_valid && (owner == master_e'(i));
      lose[i]   = req[i] && (grant != master_e'(i));
      hready[i] = bus.hready && !lose[i];
    end
  end

  // Address phase from the granted master, write data from the data-phase owner
  assign bus.hsel   = (grant == MST_NET) ? m1_hsel_i   : m0_hsel_i;
  assign bus.haddr  = (grant == MST_NET) ? m1_haddr_i  : m0_haddr_i;
  assign bus.hwrite = (grant == MST_NET) ? m1_hwrite_i : m0_hwrite_i;
  assign bus.hsize  = hsize_e'((grant == MST_NET) ? m1_hsize_i : m0_hsize_i);
  assign bus.htrans = htrans_e'((grant == MST_NET) ? m1_htrans_i : m0_htrans_i);
  assign bus.hwdata = (owner == MST_NET) ? m1_hwdata_i : m0_hwdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dp_valid <= 1'b0;
      owner    <= MST_NET;
    end else if (bus.hready) begin
      dp_valid <= |req;
      if (|req) begin
        owner <= grant;
      end
    end
  end

  // A data phase can end on the bus while its master loses the next
  // arbitration, so its response is parked until that master is granted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (own[i] && bus.hready && lose[i]) begin
          pend[i] <= 1'b1;
        end else if (hready[i]) begin
          pend[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (own[i] && bus.hready && lose[i]) begin
        hold_rdata[i] <= bus.hrdata;
        hold_resp[i]  <= bus.hresp;
      end
    end
  end

  assign m0_hready_o = hready[MST_CORE];
  assign m0_hrdata_o = pend[MST_CORE] ? hold_rdata[MST_CORE] : bus.hrdata;
  assign m0_hresp_o  = pend[MST_CORE] ? hold_resp[MST_CORE]
                                      : (own[MST_CORE] && bus.hresp);

  assign m1_hready_o = hready[MST_NET];
  assign m1_hrdata_o = pend[MST_NET] ? hold_rdata[MST_NET] : bus.hrdata;
  assign m1_hresp_o  = pend[MST_NET] ? hold_resp[MST_NET]
                                     : (own[MST_NET] && bus.hresp);

endmodule

/* hw/bus/tile_bus_decoder.sv */
`timescale 1ns/1ps

module tile_bus_decoder import tile_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  ahb_if.slave  bus,
  ahb_if.master sram,
  ahb_if.master boot,
  ahb_if.master ext
);

  logic [3:0] region;
  slave_e     addr_slave;
  slave_e     dp_slave;
  logic       dp_active;
  logic       accept;

  assign region = bus.haddr[REGION_MSB:REGION_LSB];

  always_comb begin
    case (region)
      REGION_SRAM: addr_slave = SLV_SRAM;
      REGION_EXT:  addr_slave = SLV_EXT;
      REGION_BOOT: addr_slave = SLV_BOOT;
      default:     addr_slave = SLV_NONE;
    endcase
  end

  assign accept = bus.hsel && (bus.htrans == HTRANS_NONSEQ) && bus.hready;

  // Slave selects only fire on an accepted address phase
  assign sram.hsel   = accept && (addr_slave == SLV_SRAM);
  assign sram.haddr  = bus.haddr;
  assign sram.hwdata = bus.hwdata;
  assign sram.hwrite = bus.hwrite;
  assign sram.hsize  = bus.hsize;
  assign sram.htrans = sram.hsel ? bus.htrans : HTRANS_IDLE;

  assign boot.hsel   = accept && (addr_slave == SLV_BOOT);
  assign boot.haddr  = bus.haddr;
  assign boot.hwdata = bus.hwdata;
  assign boot.hwrite = bus.hwrite;
  assign boot.hsize  = bus.hsize;
  assign boot.htrans = boot.hsel ? bus.htrans : HTRANS_IDLE;

  assign ext.hsel    = accept && (addr_slave == SLV_EXT);
  assign ext.haddr   = bus.haddr;
  assign ext.hwdata  = bus.hwdata;
  assign ext.hwrite  = bus.hwrite;
  assign ext.hsize   = bus.hsize;
  assign ext.htrans  = ext.hsel ? bus.htrans : HTRANS_IDLE;

  // Data-phase slave
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dp_active <= 1'b0;
      dp_slave  <= SLV_NONE;
    end else if (bus.hready) begin
      dp_active <= accept;
      dp_slave  <= addr_slave;
    end
  end

  always_comb begin
    bus.hrdata = '0;
    bus.hready = 1'b1;
    bus.hresp  = 1'b0;
    if (dp_active) begin
      case (dp_slave)
        SLV_SRAM: begin
          bus.hrdata = sram.hrdata;
          bus.hready = sram.hready;
          bus.hresp  = sram.hresp;
        end
        SLV_BOOT: begin
          bus.hrdata = boot.hrdata;
          bus.hready = boot.hready;
          bus.hresp  = boot.hresp;
        end
        SLV_EXT: begin
          bus.hrdata = ext.hrdata;
          bus.hready = ext.hready;
          bus.hresp  = ext.hresp;
        end
        default: begin
          // Unmapped, single cycle error
          bus.hresp = 1'b1;
        end
      endcase
    end
  end

endmodule

/* hw/mem/tile_bootrom.sv */
`timescale 1ns/1ps

module tile_bootrom import tile_pkg::*; (
  input logic  clk_i,
  input logic  reset_i,
  ahb_if.slave bus
);

  logic                          dp_valid;
  logic [$clog2(BOOT_WORDS)-1:0] dp_idx;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dp_valid <= 1'b0;
    end else begin
      dp_valid <= bus.hsel && (bus.htrans == HTRANS_NONSEQ);
    end
  end

  // Word index wraps at BOOT_WORDS
  always_ff @(posedge clk_i) begin
    if (bus.hsel && (bus.htrans == HTRANS_NONSEQ)) begin
      dp_idx <= bus.haddr[$clog2(BOOT_WORDS)+1:2];
    end
  end

  // Writes land here too and are simply dropped
  assign bus.hrdata = dp_valid ? BOOT_TABLE[dp_idx] : '0;
  assign bus.hready = 1'b1;
  assign bus.hresp  = 1'b0;

endmodule

/* hw/mem/tile_sram.sv */
`timescale 1ns/1ps

module tile_sram import tile_pkg::*; (
  input logic  clk_i,
  input logic  reset_i,
  ahb_if.slave bus
);

  logic [DATA_WIDTH-1:0] mem [0:SRAM_WORDS-1];
  logic                  dp_valid;
  logic                  dp_write;
  logic [SRAM_AW-1:0]    dp_idx;
  logic [1:0]            dp_lsb;
  hsize_e                dp_size;
  logic [3:0]            be;

  initial begin
    for (int i = 0; i < SRAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dp_valid <= 1'b0;
    end else begin
      dp_valid <= bus.hsel && (bus.htrans == HTRANS_NONSEQ);
    end
  end

  // Address phase capture, word index wraps at SRAM_WORDS
  always_ff @(posedge clk_i) begin
    if (bus.hsel && (bus.htrans == HTRANS_NONSEQ)) begin
      dp_write <= bus.hwrite;
      dp_idx   <= bus.haddr[SRAM_AW+1:2];
      dp_lsb   <= bus.haddr[1:0];
      dp_size  <= bus.hsize;
    end
  end

  // Little-endian lanes
  always_comb begin
    case (dp_size)
      HSIZE_BYTE: be = 4'b0001 << dp_lsb;
      HSIZE_HALF: be = dp_lsb[1] ? 4'b1100 : 4'b0011;
      default:    be = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (dp_valid && dp_write) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[dp_idx][8*b +: 8] <= bus.hwdata[8*b +: 8];
        end
      end
    end
  end

  assign bus.hrdata = mem[dp_idx];
  assign bus.hready = 1'b1;
  assign bus.hresp  = 1'b0;

endmodule

/* hw/tile_top.sv */
`timescale 1ns/1ps

module tile_top import tile_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Core data port
  input  logic                  m0_hsel_i,
  input  logic [ADDR_WIDTH-1:0] m0_haddr_i,
  input  logic [DATA_WIDTH-1:0] m0_hwdata_i,
  input  logic                  m0_hwrite_i,
  input  logic [2:0]            m0_hsize_i,
  input  logic [1:0]            m0_htrans_i,
  output logic [DATA_WIDTH-1:0] m0_hrdata_o,
  output logic                  m0_hready_o,
  output logic                  m0_hresp_o,

  // Network or debug master
  input  logic                  m1_hsel_i,
  input  logic [ADDR_WIDTH-1:0] m1_haddr_i,
  input  logic [DATA_WIDTH-1:0] m1_hwdata_i,
  input  logic                  m1_hwrite_i,
  input  logic [2:0]            m1_hsize_i,
  input  logic [1:0]            m1_htrans_i,
  output logic [DATA_WIDTH-1:0] m1_hrdata_o,
  output logic                  m1_hready_o,
  output logic                  m1_hresp_o,

  // External memory port
  output logic                  ext_hsel_o,
  output logic [ADDR_WIDTH-1:0] ext_haddr_o,
  output logic [DATA_WIDTH-1:0] ext_hwdata_o,
  output logic                  ext_hwrite_o,
  output logic [2:0]            ext_hsize_o,
  output logic [1:0]            ext_htrans_o,
  input  logic [DATA_WIDTH-1:0] ext_hrdata_i,
  input  logic                  ext_hready_i,
  input  logic                  ext_hresp_i
);

  ahb_if bus_if ();
  ahb_if sram_if ();
  ahb_if boot_if ();
  ahb_if ext_if ();

  tile_bus_arbiter u_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .m0_hsel_i   (m0_hsel_i),
    .m0_haddr_i  (m0_haddr_i),
    .m0_hwdata_i (m0_hwdata_i),
    .m0_hwrite_i (m0_hwrite_i),
    .m0_hsize_i  (m0_hsize_i),
    .m0_htrans_i (m0_htrans_i),
    .m0_hrdata_o (m0_hrdata_o),
    .m0_hready_o (m0_hready_o),
    .m0_hresp_o  (m0_hresp_o),
    .m1_hsel_i   (m1_hsel_i),
    .m1_haddr_i  (m1_haddr_i),
    .m1_hwdata_i (m1_hwdata_i),
    .m1_hwrite_i (m1_hwrite_i),
    .m1_hsize_i  (m1_hsize_i),
    .m1_htrans_i (m1_htrans_i),
    .m1_hrdata_o (m1_hrdata_o),
    .m1_hready_o (m1_hready_o),
    .m1_hresp_o  (m1_hresp_o),
    .bus         (bus_if.master)
  );

  tile_bus_decoder u_decoder (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (bus_if.slave),
    .sram    (sram_if.master),
    .boot    (boot_if.master),
    .ext     (ext_if.master)
  );

  tile_sram u_sram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (sram_if.slave)
  );

  tile_bootrom u_bootrom (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (boot_if.slave)
  );

  // Pass-through to the external slave
  assign ext_hsel_o    = ext_if.hsel;
  assign ext_haddr_o   = ext_if.haddr;
  assign ext_hwdata_o  = ext_if.hwdata;
  assign ext_hwrite_o  = ext_if.hwrite;
  assign ext_hsize_o   = ext_if.hsize;
  assign ext_htrans_o  = ext_if.htrans;
  assign ext_if.hrdata = ext_hrdata_i;
  assign ext_if.hready = ext_hready_i;
  assign ext_if.hresp  = ext_hresp_i;

endmodule

/* verif/tile_tb.sv */
`timescale 1ns/1ps

module tile_tb import tile_pkg::*; ();

  localparam int HALF       = 20;
  localparam int MAX_CYCLES = 4000;

  logic                  clk;
  logic                  reset_i;
  logic [1:0]            hsel_d;
  logic [1:0]            hwrite_d;
  logic [ADDR_WIDTH-1:0] haddr_d [0:1];
  logic [DATA_WIDTH-1:0] hwdata_d [0:1];
  logic [2:0]            hsize_d [0:1];
  logic [1:0]            htrans_d [0:1];
  wire  [DATA_WIDTH-1:0] m0_hrdata;
  wire  [DATA_WIDTH-1:0] m1_hrdata;
  wire  [1:0]            hready_w;
  wire  [1:0]            hresp_w;

  wire                   ext_hsel_o;
  wire  [ADDR_WIDTH-1:0] ext_haddr_o;
  wire  [DATA_WIDTH-1:0] ext_hwdata_o;
  wire                   ext_hwrite_o;
  wire  [2:0]            ext_hsize_o;
  wire  [1:0]            ext_htrans_o;
  logic [DATA_WIDTH-1:0] ext_hrdata_i;
  logic                  ext_hready_i;
  logic                  ext_hresp_i;

  logic [31:0]           lfsr;
  int                    errors = 0;
  int                    cycle_count = 0;
  int                    addr_waits [0:1];
  int                    data_cycles [0:1];

  // External slave model state
  logic [31:0]           ext_mem [logic [31:0]];
  logic                  ext_busy;
  int                    ext_wait;
  int                    ext_last_wait;
  logic [31:0]           ext_last_addr;
  logic [31:0]           ext_last_wdata;
  logic [2:0]            ext_last_size;
  logic                  ext_last_write;
  int                    stall_cycles;

  tile_top tile_top_i (
    .clk_i        (clk),
    .reset_i      (reset_i),
    .m0_hsel_i    (hsel_d[0]),
    .m0_haddr_i   (haddr_d[0]),
    .m0_hwdata_i  (hwdata_d[0]),
    .m0_hwrite_i  (hwrite_d[0]),
    .m0_hsize_i   (hsize_d[0]),
    .m0_htrans_i  (htrans_d[0]),
    .m0_hrdata_o  (m0_hrdata),
    .m0_hready_o  (hready_w[0]),
    .m0_hresp_o   (hresp_w[0]),
    .m1_hsel_i    (hsel_d[1]),
    .m1_haddr_i   (haddr_d[1]),
    .m1_hwdata_i  (hwdata_d[1]),
    .m1_hwrite_i  (hwrite_d[1]),
    .m1_hsize_i   (hsize_d[1]),
    .m1_htrans_i  (htrans_d[1]),
    .m1_hrdata_o  (m1_hrdata),
    .m1_hready_o  (hready_w[1]),
    .m1_hresp_o   (hresp_w[1]),
    .ext_hsel_o   (ext_hsel_o),
    .ext_haddr_o  (ext_haddr_o),
    .ext_hwdata_o (ext_hwdata_o),
    .ext_hwrite_o (ext_hwrite_o),
    .ext_hsize_o  (ext_hsize_o),
    .ext_htrans_o (ext_htrans_o),
    .ext_hrdata_i (ext_hrdata_i),
    .ext_hready_i (ext_hready_i),
    .ext_hresp_i  (ext_hresp_i)
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s actual %h expected %h", $time, name, act, exp));
    end
  endtask

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Expected word after a narrow little-endian write
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [2:0] size, input logic [1:0] off);
    logic [31:0] mask;
    case (size)
      HSIZE_BYTE: mask = 32'h0000_00ff << (8 * off);
      HSIZE_HALF: mask = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
      default:    mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | (wd & mask);
  endfunction

  // Starts and ends just after a falling edge
  task automatic transfer(input int m, input logic wr, input logic [31:0] addr,
                          input logic [2:0] size, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic resp);
    logic done;
    hsel_d[m]      = 1'b1;
    htrans_d[m]    = HTRANS_NONSEQ;
    haddr_d[m]     = addr;
    hwrite_d[m]    = wr;
    hsize_d[m]     = size;
    addr_waits[m]  = 0;
    data_cycles[m] = 0;
    done           = 1'b0;
    while (!done) begin
      #(HALF / 2);
      done = hready_w[m];
      if (!done) addr_waits[m]++;
      @(negedge clk);
    end
    hsel_d[m]   = 1'b0;
    htrans_d[m] = HTRANS_IDLE;
    hwdata_d[m] = wdata;
    done        = 1'b0;
    while (!done) begin
      #(HALF / 2);
      data_cycles[m]++;
      done  = hready_w[m];
      rdata = (m == 0) ? m0_hrdata : m1_hrdata;
      resp  = hresp_w[m];
      @(negedge clk);
    end
  endtask

  task automatic bus_write(input int m, input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] wdata, output logic resp);
    logic [31:0] unused;
    transfer(m, 1'b1, addr, size, wdata, unused, resp);
  endtask

  task automatic bus_read(input int m, input logic [31:0] addr, input logic [2:0] size,
                          output logic [31:0] rdata, output logic resp);
    transfer(m, 1'b0, addr, size, 32'h0, rdata, resp);
  endtask

  task automatic sram_word_access();
    logic [31:0] addrs [0:15];
    logic [31:0] exp [logic [31:0]];
    logic [31:0] data;
    logic        resp;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_bits($clog2(SRAM_WORDS)) << 2;
      data     = rand_bits(32);
      exp[addrs[i]] = data;
      bus_write(0, addrs[i], HSIZE_WORD, data, resp);
      check("m0_hresp_o", resp, 1'b0);
      check("m0 data phase cycles", data_cycles[0], 1);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(0, addrs[i], HSIZE_WORD, data, resp);
      check("m0_hrdata_o", data, exp[addrs[i]]);
      check("m0_hresp_o", resp, 1'b0);
      check("m0 data phase cycles", data_cycles[0], 1);
    end
  endtask

  task automatic byte_lane_writes();
    int          offs [0:5] = '{1, 2, 3, 0, 0, 2};
    logic [2:0]  sizes [0:5] = '{HSIZE_BYTE, HSIZE_HALF, HSIZE_BYTE,
                                 HSIZE_HALF, HSIZE_BYTE, HSIZE_BYTE};
    logic [31:0] base;
    logic [31:0] exp;
    logic [31:0] data;
    logic        resp;
    base = 32'h0000_0f00;
    exp  = rand_bits(32);
    bus_write(0, base, HSIZE_WORD, exp, resp);
    for (int k = 0; k < 6; k++) begin
      data = rand_bits(32);
      bus_write(0, base + offs[k], sizes[k], data, resp);
      check("m0_hresp_o", resp, 1'b0);
      exp = merge_lanes(exp, data, sizes[k], offs[k]);
      bus_read(0, base, HSIZE_WORD, data, resp);
      check("m0_hrdata_o", data, exp);
    end
  endtask

  task automatic boot_rom_reads();
    logic [31:0] data;
    logic        resp;
    for (int i = 0; i < BOOT_WORDS; i++) begin
      bus_read(0, 32'hf000_0000 + 4 * i, HSIZE_WORD, data, resp);
      check("m0_hrdata_o", data, BOOT_TABLE[i]);
      check("m0_hresp_o", resp, 1'b0);
    end
    bus_write(0, 32'hf000_0008, HSIZE_WORD, rand_bits(32), resp);
    check("m0_hresp_o", resp, 1'b0);
    bus_read(0, 32'hf000_0008, HSIZE_WORD, data, resp);
    check("m0_hrdata_o", data, BOOT_TABLE[2]);
  endtask

  task automatic ext_region_access();
    logic [31:0] addrs [0:7];
    logic [31:0] exp [logic [31:0]];
    logic [31:0] data;
    logic [2:0]  size;
    logic        resp;
    stall_cycles = 0;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 32'he000_0000 | (rand_bits(8) << 2);
      data     = rand_bits(32);
      exp[addrs[i]] = data;
      bus_write(0, addrs[i], HSIZE_WORD, data, resp);
      check("ext_haddr_o", ext_last_addr, addrs[i]);
      check("ext_hwdata_o", ext_last_wdata, data);
      check("ext_hwrite_o", ext_last_write, 1'b1);
      check("ext_hsize_o", ext_last_size, HSIZE_WORD);
      check("m0 data phase cycles", data_cycles[0], ext_last_wait + 1);
    end
    for (int i = 0; i < 8; i++) begin
      size = (i % 2) ? HSIZE_HALF : HSIZE_WORD;
      bus_read(0, addrs[i], size, data, resp);
      check("m0_hrdata_o", data, exp[addrs[i]]);
      check("ext_haddr_o", ext_last_addr, addrs[i]);
      check("ext_hwrite_o", ext_last_write, 1'b0);
      check("ext_hsize_o", ext_last_size, size);
      check("m0 data phase cycles", data_cycles[0], ext_last_wait + 1);
    end
    if (stall_cycles == 0) report_failure("The external slave model never inserted a wait state");
  endtask

  task automatic unmapped_region_error();
    logic [31:0] data;
    logic        resp;
    bus_read(0, 32'h5000_0010, HSIZE_WORD, data, resp);
    check("m0_hresp_o", resp, 1'b1);
    check("m0_hrdata_o", data, 32'h0);
    check("m0 data phase cycles", data_cycles[0], 1);
    bus_write(0, 32'h5000_0020, HSIZE_WORD, 32'h1234_5678, resp);
    check("m0_hresp_o", resp, 1'b1);
    bus_write(0, 32'h0000_0020, HSIZE_WORD, 32'h0bad_f00d, resp);
    check("m0_hresp_o", resp, 1'b0);
    bus_read(0, 32'h0000_0020, HSIZE_WORD, data, resp);
    check("m0_hrdata_o", data, 32'h0bad_f00d);
    check("m0_hresp_o", resp, 1'b0);
  endtask

  task automatic master_traffic(input int m, input logic [31:0] base, input int first_wait);
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        resp;
    for (int k = 0; k < 6; k++) begin
      wdata = rand_bits(32);
      bus_write(m, base + 4 * k, HSIZE_WORD, wdata, resp);
      check($sformatf("m%0d_hresp_o", m), resp, 1'b0);
      if (k == 0) begin
        check($sformatf("m%0d address wait cycles", m), addr_waits[m], first_wait);
      end
      if (addr_waits[m] > 1) report_failure($sformatf("Master %0d waited too long", m));
      bus_read(m, base + 4 * k, HSIZE_WORD, rdata, resp);
      check($sformatf("m%0d_hrdata_o", m), rdata, wdata);
      check($sformatf("m%0d data phase cycles", m), data_cycles[m], 1);
      if (addr_waits[m] > 1) report_failure($sformatf("Master %0d waited too long", m));
    end
  endtask

  task automatic two_master_contention();
    logic resp;
    // Master 0 was granted last, so master 1 wins the first contention
    fork
      master_traffic(0, 32'h0000_0400, 1);
      master_traffic(1, 32'h0000_0800, 0);
    join
    // After a lone master 1 transfer master 0 wins
    bus_write(1, 32'h0000_0c00, HSIZE_WORD, rand_bits(32), resp);
    check("m1_hresp_o", resp, 1'b0);
    fork
      master_traffic(0, 32'h0000_0400, 0);
      master_traffic(1, 32'h0000_0800, 1);
    join
  endtask

  // External slave model with 0 to 3 wait states per transfer
  initial begin
    ext_hrdata_i = '0;
    ext_hready_i = 1'b1;
    ext_hresp_i  = 1'b0;
    ext_busy     = 1'b0;
    ext_wait     = 0;
    forever begin
      @(negedge clk);
      if (ext_busy && ext_wait > 0) begin
        ext_hready_i = 1'b0;
        ext_wait--;
      end else begin
        ext_hready_i = 1'b1;
        if (ext_busy && !ext_last_write) begin
          ext_hrdata_i = ext_mem.exists(ext_last_addr) ? ext_mem[ext_last_addr] : '0;
        end
      end
      #(HALF / 2);
      if (ext_busy && !ext_hready_i) begin
        stall_cycles++;
        check("m0_hready_o", hready_w[0], 1'b0);
        check("m1_hready_o", hready_w[1], 1'b0);
      end else if (ext_busy) begin
        if (ext_last_write) begin
          ext_mem[ext_last_addr] = ext_hwdata_o;
          ext_last_wdata         = ext_hwdata_o;
        end
        ext_busy = 1'b0;
      end
      if (ext_hsel_o && (ext_htrans_o == HTRANS_NONSEQ)) begin
        ext_busy       = 1'b1;
        ext_last_addr  = ext_haddr_o;
        ext_last_write = ext_hwrite_o;
        ext_last_size  = ext_hsize_o;
        ext_wait       = rand_bits(2);
        ext_last_wait  = ext_wait;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      report_failure("Timeout, the tests ran longer than the cycle limit");
    end
  end

  initial begin
    lfsr    = 32'hf5e9;
    reset_i = 1'b1;
    hsel_d   = '0;
    hwrite_d = '0;
    for (int i = 0; i < 2; i++) begin
      haddr_d[i]  = '0;
      hwdata_d[i] = '0;
      hsize_d[i]  = HSIZE_WORD;
      htrans_d[i] = HTRANS_IDLE;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    #(HALF / 2);
    check("m0_hready_o", hready_w[0], 1'b1);
    check("m1_hready_o", hready_w[1], 1'b1);
    check("m0_hresp_o", hresp_w[0], 1'b0);
    check("m1_hresp_o", hresp_w[1], 1'b0);
    check("ext_hsel_o", ext_hsel_o, 1'b0);
    check("ext_htrans_o", ext_htrans_o, HTRANS_IDLE);
    @(negedge clk);
    sram_word_access();
    byte_lane_writes();
    boot_rom_reads();
    ext_region_access();
    unmapped_region_error();
    two_master_contention();
    if (errors == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

endmodule

/* vlog.f */
common/tile_pkg.sv
common/ahb_if.sv
hw/bus/tile_bus_arbiter.sv
hw/bus/tile_bus_decoder.sv
hw/mem/tile_sram.sv
hw/mem/tile_bootrom.sv
hw/tile_top.sv
verif/tile_tb.sv
